// File: hw/mcif_rd_arb.sv
/* mcif read arbiter
   round-robin by request between the two splitter streams */

`timescale 1ns/1ps

module mcif_rd_arb
  import mcif_rd_pkg::*;
(
  input  logic         nvdla_core_clk,
  input  logic         nvdla_core_rstn,
  input  logic         req_valid0,
  input  logic         req_valid1,
  output logic         req_ready0,
  output logic         req_ready1,
  input  mcif_addr_t   req_addr0,
  input  mcif_addr_t   req_addr1,
  input  logic         req_ltran0,
  input  logic         req_ltran1,
  output logic         out_valid,
  input  logic         out_ready,
  output mcif_addr_t   out_addr,
  output mcif_client_t out_client
);

  mcif_client_t ptr;
  mcif_client_t gnt;
  logic         gnt_ltran;
  logic         accept;

  // pointer client first, the other only while it idles
  always_comb begin
    if (ptr == 1'b0) begin
      gnt = (!req_valid0 && req_valid1) ? 1'b1 : 1'b0;
    end else begin
      gnt = (!req_valid1 && req_valid0) ? 1'b0 : 1'b1;
    end
  end

  assign out_valid  = req_valid0 | req_valid1;
  assign out_addr   = (gnt == 1'b1) ? req_addr1 : req_addr0;
  assign out_client = gnt;
  assign gnt_ltran  = (gnt == 1'b1) ? req_ltran1 : req_ltran0;

  // only the granted side sees ready
  assign req_ready0 = out_ready & (gnt == 1'b0);
  assign req_ready1 = out_ready & (gnt == 1'b1);

  assign accept = out_valid & out_ready;

  // ======================================================================
  // priority pointer
  // ======================================================================

  // stays on the granted client until its last beat,
  // then hands over to the other one
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ptr <= 1'b0;
    end else if (accept) begin
      if (gnt_ltran) begin
        ptr <= ~gnt;
      end else begin
        ptr <= gnt;
      end
    end
  end

endmodule

// File: hw/mcif_rd_axi_out.sv
/* mcif read output stage
   axi4-lite ar register, plus an order queue that steers r data to clients */

`timescale 1ns/1ps

module mcif_rd_axi_out
  import mcif_rd_pkg::*;
#(
  parameter int ORDER_DEPTH = 8
) (
  input  logic         nvdla_core_clk,
  input  logic         nvdla_core_rstn,
  input  logic         in_valid,
  output logic         in_ready,
  input  mcif_addr_t   in_addr,
  input  mcif_client_t in_client,
  output logic         arvalid,
  input  logic         arready,
  output mcif_addr_t   araddr,
  input  logic         rvalid,
  output logic         rready,
  input  mcif_data_t   rdata,
  output logic         rd_valid0,
  output logic         rd_valid1,
  output mcif_data_t   rd_data0,
  output mcif_data_t   rd_data1
);

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(ORDER_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ORDER_DEPTH);

  logic                        arvalid_q;
  mcif_addr_t                  araddr_q;
  logic                        load;
  logic                        pop;
  logic                        ord_full;
  mcif_client_t                ord_mem [ORDER_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            ord_cnt;
  logic                        rd_vld_q;
  mcif_client_t                rd_client_q;
  mcif_data_t                  rd_data_q;
  logic [MCIF_NUM_CLIENTS-1:0] rd_sel;

  // wrap at the queue depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == LAST_PTR) ? '0 : p + 1'b1;
  endfunction

  // ======================================================================
  // ar channel
  // ======================================================================

  // free when empty or leaving, and a return slot is left
  assign in_ready = (~arvalid_q | arready) & ~ord_full;
  assign load     = in_valid & in_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      arvalid_q <= 1'b0;
    end else if (load) begin
      arvalid_q <= 1'b1;
    end else if (arready) begin
      arvalid_q <= 1'b0;
    end
  end

  // address holds until the slave takes it
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      araddr_q <= in_addr;
    end
  end

  assign arvalid = arvalid_q;
  assign araddr  = araddr_q;

  // ======================================================================
  // order queue
  // ======================================================================

  // clients never stall return data
  assign rready   = 1'b1;
  assign pop      = rvalid;
  // counts beats from load until their data returns
  assign ord_full = (ord_cnt == FULL_CNT);

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      ord_mem[wr_ptr] <= in_client;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      ord_cnt <= '0;
    end else begin
      if (load) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (load && !pop) begin
        ord_cnt <= ord_cnt + 1'b1;
      end else if (pop && !load) begin
        ord_cnt <= ord_cnt - 1'b1;
      end
    end
  end

  // ======================================================================
  // r data return
  // ======================================================================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rvalid;
    end
  end

  // data and its owner, taken from queue head
  always_ff @(posedge nvdla_core_clk) begin
    if (rvalid) begin
      rd_data_q   <= rdata;
      rd_client_q <= ord_mem[rd_ptr];
    end
  end

  // one-hot steer to the owning client
  always_comb begin
    rd_sel              = '0;
    rd_sel[rd_client_q] = rd_vld_q;
  end

  assign rd_valid0 = rd_sel[0];
  assign rd_valid1 = rd_sel[1];
  // shared data bus, valid tells who owns it
  assign rd_data0  = rd_data_q;
  assign rd_data1  = rd_data_q;

endmodule

// File: hw/mcif_rd_bpt.sv
/* mcif read splitter
   breaks one client request into single 8-byte beats, with credit stall */

`timescale 1ns/1ps

module mcif_rd_bpt
  import mcif_rd_pkg::*;
#(
  parameter logic [7:0] LAT_DEPTH = 8'd0
) (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       in_valid,
  output logic       in_ready,
  input  mcif_addr_t in_addr,
  input  mcif_len_t  in_len,
  input  logic       cdt_pop,
  output logic       out_valid,
  input  logic       out_ready,
  output mcif_addr_t out_addr,
  output logic       out_ltran
);

  mcif_beat_cnt_t beat_cnt;
  mcif_addr_t     addr_q;
  logic [7:0]     cdt_cnt;
  logic           pop_q;
  logic           stall_en;
  logic           cdt_ok;
  logic           cdt_inc;
  logic           cdt_dec;
  logic           is_first;
  logic           is_last;
  logic           accept;

  // ======================================================================
  // latency buffer credit
  // ======================================================================

  // depth of zero turns stalling off
  assign stall_en = (LAT_DEPTH != 8'd0);

  // pop from client side, registered once
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pop_q <= 1'b0;
    end else begin
      pop_q <= cdt_pop;
    end
  end

  // one credit per issued beat
  assign cdt_inc = accept & stall_en;
  // credit back one cycle after the pop
  assign cdt_dec = pop_q & stall_en;

  // beats in flight towards the latency buffer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cdt_cnt <= 8'd0;
    end else if (cdt_inc != cdt_dec) begin
      cdt_cnt <= cdt_cnt + {7'd0, cdt_inc} - {7'd0, cdt_dec};
    end
  end

  // buffer full, stop issuing
  assign cdt_ok = ~stall_en | (cdt_cnt != LAT_DEPTH);

  // ======================================================================
  // beat sequencing
  // ======================================================================

  assign is_first = (beat_cnt == '0);
  assign is_last  = ({1'b0, beat_cnt} == in_len);

  // a beat goes out only while credit remains
  assign out_valid = in_valid & cdt_ok;
  assign accept    = out_valid & out_ready;

  // request leaves the pipe with its last beat
  assign in_ready  = accept & is_last;

  // position inside the current request
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_cnt <= '0;
    end else if (accept) begin
      if (is_last) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 14'd1;
      end
    end
  end

  // next beat address
  // first beat starts from the request, later ones step on
  always_ff @(posedge nvdla_core_clk) begin
    if (accept) begin
      if (is_first) begin
        addr_q <= in_addr + MCIF_BEAT_BYTES;
      end else begin
        addr_q <= addr_q + MCIF_BEAT_BYTES;
      end
    end
  end

  // ======================================================================
  // beat out
  // ======================================================================

  assign out_addr  = is_first ? in_addr : addr_q;
  assign out_ltran = is_last;

endmodule

// File: hw/mcif_rd_ig.sv
/* mcif read ingress top
   two client pipes and splitters, round-robin arbiter, axi4-lite output */

`timescale 1ns/1ps

module mcif_rd_ig
  import mcif_rd_pkg::*;
#(
  parameter logic [7:0] LAT_DEPTH0  = 8'd8,
  parameter logic [7:0] LAT_DEPTH1  = 8'd8,
  parameter int         ORDER_DEPTH = 8
) (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       req_valid0,
  output logic       req_ready0,
  input  mcif_addr_t req_addr0,
  input  mcif_len_t  req_len0,
  input  logic       req_valid1,
  output logic       req_ready1,
  input  mcif_addr_t req_addr1,
  input  mcif_len_t  req_len1,
  input  logic       rd_pop0,
  input  logic       rd_pop1,
  output logic       arvalid,
  input  logic       arready,
  output mcif_addr_t araddr,
  input  logic       rvalid,
  output logic       rready,
  input  mcif_data_t rdata,
  output logic       rd_valid0,
  output logic       rd_valid1,
  output mcif_data_t rd_data0,
  output mcif_data_t rd_data1
);

  // pipe to splitter
  logic         pipe_valid0, pipe_valid1;
  logic         pipe_ready0, pipe_ready1;
  mcif_addr_t   pipe_addr0, pipe_addr1;
  mcif_len_t    pipe_len0, pipe_len1;
  // splitter to arbiter
  logic         bpt_valid0, bpt_valid1;
  logic         bpt_ready0, bpt_ready1;
  mcif_addr_t   bpt_addr0, bpt_addr1;
  logic         bpt_ltran0, bpt_ltran1;
  // arbiter to output stage
  logic         arb_valid;
  logic         arb_ready;
  mcif_addr_t   arb_addr;
  mcif_client_t arb_client;

  // ======================================================================
  // client 0 request path
  // ======================================================================

  mcif_rd_pipe u_pipe0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (req_valid0),
    .in_ready        (req_ready0),
    .in_addr         (req_addr0),
    .in_len          (req_len0),
    .out_valid       (pipe_valid0),
    .out_ready       (pipe_ready0),
    .out_addr        (pipe_addr0),
    .out_len         (pipe_len0)
  );

  mcif_rd_bpt #(.LAT_DEPTH(LAT_DEPTH0)) u_bpt0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (pipe_valid0),
    .in_ready        (pipe_ready0),
    .in_addr         (pipe_addr0),
    .in_len          (pipe_len0),
    .cdt_pop         (rd_pop0),
    .out_valid       (bpt_valid0),
    .out_ready       (bpt_ready0),
    .out_addr        (bpt_addr0),
    .out_ltran       (bpt_ltran0)
  );

  // ======================================================================
  // client 1 request path
  // ======================================================================

  mcif_rd_pipe u_pipe1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (req_valid1),
    .in_ready        (req_ready1),
    .in_addr         (req_addr1),
    .in_len          (req_len1),
    .out_valid       (pipe_valid1),
    .out_ready       (pipe_ready1),
    .out_addr        (pipe_addr1),
    .out_len         (pipe_len1)
  );

  mcif_rd_bpt #(.LAT_DEPTH(LAT_DEPTH1)) u_bpt1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (pipe_valid1),
    .in_ready        (pipe_ready1),
    .in_addr         (pipe_addr1),
    .in_len          (pipe_len1),
    .cdt_pop         (rd_pop1),
    .out_valid       (bpt_valid1),
    .out_ready       (bpt_ready1),
    .out_addr        (bpt_addr1),
    .out_ltran       (bpt_ltran1)
  );

  // ======================================================================
  // merge and memory side
  // ======================================================================

  mcif_rd_arb u_arb (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid0      (bpt_valid0),
    .req_valid1      (bpt_valid1),
    .req_ready0      (bpt_ready0),
    .req_ready1      (bpt_ready1),
    .req_addr0       (bpt_addr0),
    .req_addr1       (bpt_addr1),
    .req_ltran0      (bpt_ltran0),
    .req_ltran1      (bpt_ltran1),
    .out_valid       (arb_valid),
    .out_ready       (arb_ready),
    .out_addr        (arb_addr),
    .out_client      (arb_client)
  );

  mcif_rd_axi_out #(.ORDER_DEPTH(ORDER_DEPTH)) u_axi_out (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (arb_valid),
    .in_ready        (arb_ready),
    .in_addr         (arb_addr),
    .in_client       (arb_client),
    .arvalid         (arvalid),
    .arready         (arready),
    .araddr          (araddr),
    .rvalid          (rvalid),
    .rready          (rready),
    .rdata           (rdata),
    .rd_valid0       (rd_valid0),
    .rd_valid1       (rd_valid1),
    .rd_data0        (rd_data0),
    .rd_data1        (rd_data1)
  );

endmodule

// File: hw/mcif_rd_pipe.sv
/* mcif read request pipe
   one-entry register stage between a dma client and its splitter */

`timescale 1ns/1ps

module mcif_rd_pipe
  import mcif_rd_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       in_valid,
  output logic       in_ready,
  input  mcif_addr_t in_addr,
  input  mcif_len_t  in_len,
  output logic       out_valid,
  input  logic       out_ready,
  output mcif_addr_t out_addr,
  output mcif_len_t  out_len
);

  logic       rdy_en;
  logic       vld_q;
  logic       load;
  mcif_addr_t addr_q;
  mcif_len_t  len_q;

  // hold off the client for one cycle after reset release
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rdy_en <= 1'b0;
    end else begin
      rdy_en <= 1'b1;
    end
  end

  // accept when empty or when the held entry leaves this cycle
  assign in_ready = rdy_en & (~vld_q | out_ready);
  assign load     = in_valid & in_ready;

  // valid follows the input whenever a slot opens
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      vld_q <= 1'b0;
    end else if (in_ready) begin
      vld_q <= in_valid;
    end
  end

  // payload
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      addr_q <= in_addr;
      len_q  <= in_len;
    end
  end

  assign out_valid = vld_q;
  assign out_addr  = addr_q;
  assign out_len   = len_q;

endmodule

// File: hw/mcif_rd_pkg.sv
/* mcif read ingress shared types
   address, length, beat, data and client index widths plus constants */

package mcif_rd_pkg;

  // ======================================================================
  // request side types
  // ======================================================================

  // byte address of a request or a single beat
  typedef logic [31:0] mcif_addr_t;

  // request length in 8-byte beats, minus one
  typedef logic [14:0] mcif_len_t;

  // beat position inside one request
  typedef logic [13:0] mcif_beat_cnt_t;

  // ======================================================================
  // return side types
  // ======================================================================

  // one read data beat from memory
  typedef logic [63:0] mcif_data_t;

  // which dma client a beat belongs to
  typedef logic [0:0] mcif_client_t;

  // ======================================================================
  // constants
  // ======================================================================

  // address step between consecutive beats
  localparam mcif_addr_t MCIF_BEAT_BYTES = 32'd8;

  // number of dma read clients
  localparam int MCIF_NUM_CLIENTS = 2;

endpackage

// File: sim/mcif_rd_chk.sv
/* read ingress protocol checks
   ar hold under back-pressure and return data only after an issued address */

`timescale 1ns/1ps

module mcif_rd_chk
  import mcif_rd_pkg::*;
(
  input logic       nvdla_core_clk,
  input logic       nvdla_core_rstn,
  input logic       arvalid,
  input logic       arready,
  input mcif_addr_t araddr,
  input logic       rd_valid0,
  input logic       rd_valid1
);

  int unsigned fail_cnt = 0;
  logic [7:0]  pend_cnt;
  logic        ar_fire;
  logic        rd_any;

  assign ar_fire = arvalid & arready;
  assign rd_any  = rd_valid0 | rd_valid1;

  // ar beats still waiting for their data
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pend_cnt <= 8'd0;
    end else begin
      pend_cnt <= pend_cnt + {7'd0, ar_fire} - {7'd0, rd_any};
    end
  end

  // ======================================================================
  // assertions
  // ======================================================================

  // address phase holds until taken
  a_ar_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("ar channel moved while arready was low");
      fail_cnt++;
    end

  a_rd_after_ar: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rd_any |-> pend_cnt != 8'd0)
    else begin
      $error("return beat with no earlier ar transfer");
      fail_cnt++;
    end

endmodule

bind mcif_rd_ig mcif_rd_chk u_chk (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .arvalid         (arvalid),
  .arready         (arready),
  .araddr          (araddr),
  .rd_valid0       (rd_valid0),
  .rd_valid1       (rd_valid1)
);

// File: sim/tb_mcif_rd.sv
/* read ingress testbench
   drives both dma clients, models an axi4-lite memory, checks ar order and returns */

`timescale 1ns/1ps

module tb_mcif_rd;
  import mcif_rd_pkg::*;

  localparam logic [7:0] LAT0     = 8'd4;
  localparam logic [7:0] LAT1     = 8'd0;
  localparam int         NUM_RAND = 6;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       req_valid0, req_valid1;
  logic       req_ready0, req_ready1;
  mcif_addr_t req_addr0, req_addr1;
  mcif_len_t  req_len0, req_len1;
  logic       rd_pop0, rd_pop1;
  logic       arvalid, arready, rvalid, rready;
  mcif_addr_t araddr;
  mcif_data_t rdata;
  logic       rd_valid0, rd_valid1;
  mcif_data_t rd_data0, rd_data1;

  // expected beats per client from the reference expansion
  mcif_addr_t   exp_addr[2][$];
  bit           exp_last[2][$];
  // issued beats awaiting data plus the memory's own order
  mcif_addr_t   issued[2][$];
  mcif_addr_t   mem_q[$];
  int           ar_cnt[2]    = '{0, 0};
  int           ret_cnt[2]   = '{0, 0};
  int           pop_cnt[2]   = '{0, 0};
  int           pop_limit[2] = '{32'h7fff_ffff, 32'h7fff_ffff};
  int           addr_errs    = 0;
  int           data_errs    = 0;
  int           proto_errs   = 0;
  int           cyc          = 0;
  int           cyc_limit    = 1000;
  int           total_beats;
  int           base;
  integer       seed;
  bit           mid_req      = 1'b0;
  mcif_client_t mid_client   = 1'b0;
  mcif_addr_t   r_addr0[NUM_RAND];
  mcif_addr_t   r_addr1[NUM_RAND];
  mcif_len_t    r_len0[NUM_RAND];
  mcif_len_t    r_len1[NUM_RAND];

  mcif_rd_ig #(
    .LAT_DEPTH0  (LAT0),
    .LAT_DEPTH1  (LAT1),
    .ORDER_DEPTH (8)
  ) UUT (.*);

  initial nvdla_core_clk = 1'b0;
  always #2 nvdla_core_clk = ~nvdla_core_clk;

  // ======================================================================
  // reference model
  // ======================================================================

  // one 8-byte beat per length step with the address climbing by 8
  function automatic void expand_req(input int c, input mcif_addr_t addr, input mcif_len_t len);
    for (int i = 0; i <= int'(len); i++) begin
      exp_addr[c].push_back(addr + mcif_addr_t'(i) * 32'd8);
      exp_last[c].push_back(i == int'(len));
    end
  endfunction

  // memory content seen at a byte address
  function automatic mcif_data_t mem_hash(input mcif_addr_t a);
    return {a ^ 32'h5bd1_e995, ~a + 32'h9e37_79b9};
  endfunction

  function automatic int total_errors();
    return addr_errs + data_errs + proto_errs + int'(UUT.u_chk.fail_cnt);
  endfunction

  task automatic print_counts();
    $display("errors: araddr %0d, rd_data %0d, protocol %0d, assertion %0d",
             addr_errs, data_errs, proto_errs, UUT.u_chk.fail_cnt);
  endtask

  // ======================================================================
  // client drivers
  // ======================================================================

  // hold the request until ready is seen before an edge
  task automatic send_req(input int c, input mcif_addr_t addr, input mcif_len_t len);
    logic hs;
    expand_req(c, addr, len);
    if (c == 0) begin
      req_valid0 = 1'b1;
      req_addr0  = addr;
      req_len0   = len;
    end else begin
      req_valid1 = 1'b1;
      req_addr1  = addr;
      req_len1   = len;
    end
    hs = 1'b0;
    while (!hs) begin
      @(negedge nvdla_core_clk);
      hs = (c == 0) ? req_ready0 : req_ready1;
      @(posedge nvdla_core_clk);
      #0.5;
    end
    if (c == 0) begin
      req_valid0 = 1'b0;
    end else begin
      req_valid1 = 1'b0;
    end
  endtask

  // wait until all beats are issued, returned and popped and credit has settled
  task automatic wait_drain(input int c);
    while (exp_addr[c].size() != 0 || issued[c].size() != 0 || pop_cnt[c] != ret_cnt[c]) begin
      @(posedge nvdla_core_clk);
      #0.5;
    end
    repeat (2) @(posedge nvdla_core_clk);
    #0.5;
  endtask

  task automatic wait_beats(input int c, input int n);
    while (ar_cnt[c] < n) begin
      @(posedge nvdla_core_clk);
      #0.5;
    end
  endtask

  // ======================================================================
  // memory responder and pop driver
  // ======================================================================

  // in-order answers with random ar back-pressure and r gaps
  always @(posedge nvdla_core_clk) begin
    #0.5;
    arready = (($random(seed) & 3) != 0);
    if (mem_q.size() != 0 && (($random(seed) & 3) != 0)) begin
      rvalid = 1'b1;
      rdata  = mem_hash(mem_q.pop_front());
    end else begin
      rvalid = 1'b0;
    end
    // latency buffer drains one beat per cycle while allowed
    rd_pop0 = (pop_cnt[0] < ret_cnt[0]) && (pop_cnt[0] < pop_limit[0]);
    rd_pop1 = (pop_cnt[1] < ret_cnt[1]) && (pop_cnt[1] < pop_limit[1]);
    if (rd_pop0) pop_cnt[0]++;
    if (rd_pop1) pop_cnt[1]++;
  end

  // ======================================================================
  // comparing process
  // ======================================================================

  task automatic check_ar();
    mcif_client_t c;
    mcif_addr_t   exp;
    bit           last;
    // client 1 lives in the upper half of the address map
    c = araddr[31];
    assert (exp_addr[c].size() != 0) else begin
      $display("AR beat at %h arrived with no open request for client %0d", araddr, c);
      proto_errs++;
    end
    if (exp_addr[c].size() != 0) begin
      exp  = exp_addr[c].pop_front();
      last = exp_last[c].pop_front();
      assert (araddr == exp) else begin
        $display("ERROR araddr client %0d: expected %h, got %h", c, exp, araddr);
        addr_errs++;
      end
      assert (!mid_req || c == mid_client) else begin
        $display("client %0d beat cut into an unfinished request of client %0d", c, mid_client);
        proto_errs++;
      end
      mid_req    = !last;
      mid_client = c;
    end
    ar_cnt[c]++;
    issued[c].push_back(araddr);
    mem_q.push_back(araddr);
  endtask

  task automatic check_rd(input int c, input mcif_data_t data);
    mcif_data_t exp;
    assert (issued[c].size() != 0) else begin
      $display("read data reached client %0d with no address issued", c);
      proto_errs++;
    end
    if (issued[c].size() != 0) begin
      exp = mem_hash(issued[c].pop_front());
      assert (data == exp) else begin
        $display("ERROR rd_data%0d: expected %h, got %h", c, exp, data);
        data_errs++;
      end
    end
    ret_cnt[c]++;
  endtask

  // sampled mid-cycle where every handshake has settled
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      cyc++;
      if (cyc > cyc_limit) begin
        $display("timeout: run still busy after %0d cycles", cyc);
        print_counts();
        $display("Simulation failed");
        $finish;
      end else begin
        // clients never stall the r channel
        assert (rready == 1'b1) else begin
          $display("ERROR rready: expected 1, got %h", rready);
          proto_errs++;
        end
        if (arvalid && arready) check_ar();
        if (rd_valid0) check_rd(0, rd_data0);
        if (rd_valid1) check_rd(1, rd_data1);
      end
    end
  end

  // ======================================================================
  // stimulus
  // ======================================================================

  initial begin
    seed            = 32'h121b_ffa1;
    nvdla_core_rstn = 1'b0;
    req_valid0      = 1'b0;
    req_valid1      = 1'b0;
    req_addr0       = '0;
    req_addr1       = '0;
    req_len0        = '0;
    req_len1        = '0;
    rd_pop0         = 1'b0;
    rd_pop1         = 1'b0;
    arready         = 1'b0;
    rvalid          = 1'b0;
    rdata           = '0;
    // random mixed traffic drawn before time moves
    total_beats = 52 + 8;
    for (int i = 0; i < NUM_RAND; i++) begin
      r_addr0[i]  = 32'h2000_0000 | ($random(seed) & 32'h000f_ffff);
      r_len0[i]   = mcif_len_t'($random(seed) & 3);
      r_addr1[i]  = 32'ha000_0000 | ($random(seed) & 32'h000f_ffff);
      r_len1[i]   = mcif_len_t'($random(seed) & 7);
      total_beats = total_beats + int'(r_len0[i]) + int'(r_len1[i]) + 2;
    end
    cyc_limit = 4 * total_beats + 200;
    repeat (5) @(posedge nvdla_core_clk);
    #0.5;
    nvdla_core_rstn = 1'b1;
    @(posedge nvdla_core_clk);
    #0.5;

    // splitting with one client at a time and unaligned starts
    send_req(0, 32'h1000_0003, 15'd0);
    send_req(0, 32'h1000_0105, 15'd3);
    send_req(0, 32'h1000_1002, 15'd20);
    wait_drain(0);
    send_req(1, 32'h8000_0007, 15'd0);
    send_req(1, 32'h8000_0201, 15'd3);
    send_req(1, 32'h8000_2006, 15'd20);
    wait_drain(1);

    // credit stall with pops held back and released one at a time
    pop_limit[0] = pop_cnt[0];
    base         = ar_cnt[0];
    send_req(0, 32'h1800_0004, 15'd7);
    wait_beats(0, base + 4);
    repeat (20) @(posedge nvdla_core_clk);
    #0.5;
    assert (ar_cnt[0] == base + 4) else begin
      $display("client 0 issued more beats than its credit allows");
      proto_errs++;
    end
    pop_limit[0] = pop_cnt[0] + 1;
    wait_beats(0, base + 5);
    repeat (20) @(posedge nvdla_core_clk);
    #0.5;
    assert (ar_cnt[0] == base + 5) else begin
      $display("a single pop let client 0 issue more than one beat");
      proto_errs++;
    end
    pop_limit[0] = 32'h7fff_ffff;
    wait_drain(0);

    // both clients loaded under random back-pressure
    // client 0 starts each request on full credit so it never stalls mid-request
    fork
      for (int i = 0; i < NUM_RAND; i++) begin
        send_req(1, r_addr1[i], r_len1[i]);
      end
      for (int i = 0; i < NUM_RAND; i++) begin
        wait_drain(0);
        send_req(0, r_addr0[i], r_len0[i]);
      end
    join
    wait_drain(0);
    wait_drain(1);

    assert (ar_cnt[0] + ar_cnt[1] == total_beats) else begin
      $display("AR beat total %0d does not match %0d requested", ar_cnt[0] + ar_cnt[1],
               total_beats);
      proto_errs++;
    end
    print_counts();
    if (total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb.f
hw/mcif_rd_pkg.sv
hw/mcif_rd_pipe.sv
hw/mcif_rd_bpt.sv
hw/mcif_rd_arb.sv
hw/mcif_rd_axi_out.sv
hw/mcif_rd_ig.sv
sim/mcif_rd_chk.sv
sim/tb_mcif_rd.sv
